/* include/spi_hub_cfg.svh */
`ifndef SPI_HUB_CFG_SVH
`define SPI_HUB_CFG_SVH

////////////////////////////////////////
// frame format

`define SPI_FRAME_BITS 16     // addr byte then value byte
`define SPI_CNT_BITS   5      // bit counter, saturates at 31

////////////////////////////////////////
// register map

`define ADDR_LED 8'd7         // led latch
`define ADDR_MUX 8'd8         // peripheral select mask
`define ADDR_DAC 8'd9         // dac control lines

////////////////////////////////////////
// pins and peripherals

`define SYNC_STAGES 2         // flops per pin synchronizer
`define NUM_PERIPH  3         // adc bit 0, dac bit 1, flash bit 2

`endif

/* verilog/spi_hub_pkg.sv */
package spi_hub_pkg;

  // plain register write, high byte addr, low byte value
  typedef struct packed {
    logic [7:0] reg_addr;
    logic [7:0] reg_value;
  } spi_wr_t;

  // same word seen as dac control, low nibble only
  typedef struct packed {
    logic [7:0] reg_addr;
    logic [3:0] unused;       // don't care
    logic       uni_bip_b;
    logic       uni_bip_a;
    logic       dac_rst;
    logic       ldac;         // lsb
  } spi_dac_t;

  // one 16 bit frame, decoded either way by address
  typedef union packed {
    spi_wr_t  wr;
    spi_dac_t dac;
  } spi_frame_u;

endpackage

/* verilog/spi_hub_links.sv */
`include "spi_hub_cfg.svh"

////////////////////////////////////////
// synchronized pin samples, sync -> shifter

interface spi_sample_if;
  logic sclk_rise;            // one clk pulse
  logic cs_rise;              // one clk pulse, end of frame
  logic cs_active;            // cs low, level
  logic mosi;                 // level, aligned to sclk_rise
  logic special_n;            // special pin level, low = reg write

  modport src (output sclk_rise, cs_rise, cs_active, mosi, special_n);
  modport dst (input  sclk_rise, cs_rise, cs_active, mosi, special_n);
endinterface

////////////////////////////////////////
// completed frames, shifter -> decoder

interface spi_frame_if
  import spi_hub_pkg::*;
();
  logic                     frame_valid;  // exactly 16 bits seen
  logic                     frame_err;    // wrong count, never with valid
  spi_frame_u               frame;        // held while frame_valid
  logic [`SPI_CNT_BITS-1:0] err_len;      // bit count of the frame

  modport src (output frame_valid, frame_err, frame, err_len);
  modport dst (input  frame_valid, frame_err, frame, err_len);
endinterface

/* verilog/spi_input_sync.sv */
`include "spi_hub_cfg.svh"

module spi_input_sync (
  input logic       clk,
  input logic       reset,
  input logic       sclk,
  input logic       cs,
  input logic       mosi,
  input logic       special,
  spi_sample_if.src smp
);

  // bit positions in the pin vector
  localparam int PIN_SCLK    = 0;
  localparam int PIN_CS      = 1;
  localparam int PIN_MOSI    = 2;
  localparam int PIN_SPECIAL = 3;

  // idle levels, cs and special both high
  localparam logic [3:0] PIN_IDLE = 4'b1010;

  logic [3:0] sync_q [`SYNC_STAGES];  // [0] nearest the pins
  logic [3:0] pins_s;                 // last stage, clk domain
  logic       sclk_prev;
  logic       cs_prev;

  assign pins_s = sync_q[`SYNC_STAGES-1];

  ////////////////////////////////////////
  // synchronizer chain, all four pins

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `SYNC_STAGES; i++)
        sync_q[i] <= PIN_IDLE;        // cs high, no false edge
    end
    else
    begin
      sync_q[0] <= {special, mosi, cs, sclk};
      for (int i = 1; i < `SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
    end
  end

  ////////////////////////////////////////
  // edge detect, registered outputs

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sclk_prev     <= 1'b0;
      cs_prev       <= 1'b1;
      smp.sclk_rise <= 1'b0;
      smp.cs_rise   <= 1'b0;
      smp.cs_active <= 1'b0;
      smp.mosi      <= 1'b0;
      smp.special_n <= 1'b1;
    end
    else
    begin
      sclk_prev     <= pins_s[PIN_SCLK];
      cs_prev       <= pins_s[PIN_CS];
      smp.sclk_rise <= pins_s[PIN_SCLK] & ~sclk_prev;   // 0 -> 1
      smp.cs_rise   <= pins_s[PIN_CS] & ~cs_prev;       // frame done
      smp.cs_active <= ~pins_s[PIN_CS];
      smp.mosi      <= pins_s[PIN_MOSI];                // same delay as pulses
      smp.special_n <= pins_s[PIN_SPECIAL];
    end
  end

endmodule

/* verilog/spi_frame_shifter.sv */
`include "spi_hub_cfg.svh"

module spi_frame_shifter
  import spi_hub_pkg::*;
(
  input logic       clk,
  input logic       reset,
  spi_sample_if.dst smp,
  spi_frame_if.src  frm
);

  logic [`SPI_FRAME_BITS-1:0] shreg;    // msb first, bits enter at [0]
  logic [`SPI_CNT_BITS-1:0]   bit_cnt;
  logic                       started;  // first bit of frame seen
  logic                       accept;   // first bit saw special low
  logic                       take_bit;
  logic                       bit_evt;

  assign bit_evt = smp.sclk_rise & smp.cs_active;

  // first bit decides from the live level, later bits from the latch
  assign take_bit = started ? accept : ~smp.special_n;

  ////////////////////////////////////////
  // bit counting and frame check

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bit_cnt         <= '0;
      started         <= 1'b0;
      accept          <= 1'b0;
      frm.frame_valid <= 1'b0;
      frm.frame_err   <= 1'b0;
      frm.err_len     <= '0;
    end
    else
    begin
      frm.frame_valid <= 1'b0;          // pulses by default
      frm.frame_err   <= 1'b0;
      if (smp.cs_rise)
      begin
        // count stays 0 for bus traffic, so no pulse then
        frm.frame_valid <= (bit_cnt == `SPI_FRAME_BITS);
        frm.frame_err   <= (bit_cnt != '0) && (bit_cnt != `SPI_FRAME_BITS);
        frm.err_len     <= bit_cnt;
        bit_cnt         <= '0;
        started         <= 1'b0;
        accept          <= 1'b0;
      end
      else if (bit_evt)
      begin
        started <= 1'b1;
        if (!started)
          accept <= ~smp.special_n;     // latch frame type
        if (take_bit && bit_cnt != '1)
          bit_cnt <= bit_cnt + 1'b1;    // saturate at 31
      end
    end
  end

  ////////////////////////////////////////
  // data path

  always_ff @(posedge clk)
  begin
    if (smp.cs_rise)
    begin
      frm.frame <= spi_frame_u'(shreg); // hold for the decoder
      shreg     <= '0;
    end
    else if (bit_evt && take_bit)
      shreg <= {shreg[`SPI_FRAME_BITS-2:0], smp.mosi};
  end

endmodule

/* verilog/reg_bank_decode.sv */
`include "spi_hub_cfg.svh"

module reg_bank_decode (
  input  logic       clk,
  input  logic       reset,
  spi_frame_if.dst   frm,
  output logic [7:0] reg_mux,
  output logic [7:0] reg_led,
  output logic [3:0] reg_dac,
  output logic [7:0] bad_frames
);

  logic bad_len;  // rejected frame that actually carried bits

  assign bad_len = frm.frame_err && (frm.err_len != '0);

  ////////////////////////////////////////
  // register writes

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      reg_mux <= '0;                    // all peripherals deselected
      reg_led <= '0;
      reg_dac <= '0;
    end
    else if (frm.frame_valid)
    begin
      case (frm.frame.wr.reg_addr)      // high byte selects
        `ADDR_MUX: reg_mux <= frm.frame.wr.reg_value;
        `ADDR_LED: reg_led <= frm.frame.wr.reg_value;
        `ADDR_DAC:
        begin
          // msb to lsb, matches the top level pin order
          reg_dac <= {frm.frame.dac.uni_bip_b,
                      frm.frame.dac.uni_bip_a,
                      frm.frame.dac.dac_rst,
                      frm.frame.dac.ldac};
        end
        default: ;                      // unknown addr, dropped
      endcase
    end
  end

  ////////////////////////////////////////
  // bad frame counter

  always_ff @(posedge clk)
  begin
    if (reset)
      bad_frames <= '0;
    else if (bad_len && bad_frames != '1)
      bad_frames <= bad_frames + 1'b1;  // stick at 255
  end

endmodule

/* verilog/periph_spi_router.sv */
`include "spi_hub_cfg.svh"

module periph_spi_router (
  input  logic                   cs,
  input  logic                   sclk,
  input  logic                   mosi,
  input  logic                   special,
  input  logic [7:0]             reg_mux,
  input  logic [`NUM_PERIPH-1:0] periph_miso,
  output logic [`NUM_PERIPH-1:0] periph_cs,
  output logic [`NUM_PERIPH-1:0] periph_sclk,
  output logic [`NUM_PERIPH-1:0] periph_mosi,
  output logic                   miso
);

  logic                   bus_open;  // master talking to peripherals
  logic [`NUM_PERIPH-1:0] sel;       // mask bits for real peripherals

  // special low means a register write, keep peripherals out of it
  assign bus_open = ~cs & special;
  assign sel      = reg_mux[`NUM_PERIPH-1:0];

  ////////////////////////////////////////
  // chip selects, active low

  assign periph_cs = ~(sel & {`NUM_PERIPH{bus_open}});

  // clock and data go everywhere, cs does the gating
  assign periph_sclk = {`NUM_PERIPH{sclk}};
  assign periph_mosi = {`NUM_PERIPH{mosi}};

  ////////////////////////////////////////
  // return path

  assign miso = |(periph_miso & sel);  // any selected one high

endmodule

/* verilog/spi_periph_hub.sv */
`include "spi_hub_cfg.svh"

module spi_periph_hub (
  input  logic       clk,
  input  logic       reset,
  // mcu spi port
  input  logic       spi_clk,
  input  logic       spi_cs,
  input  logic       spi_mosi,
  input  logic       spi_special,
  output logic       spi_miso,
  // board lines
  output logic [1:0] led,
  output logic       dac_ldac,
  output logic       dac_rst,
  output logic       dac_uni_bip_a,
  output logic       dac_uni_bip_b,
  // adc
  output logic       adc_cs,
  output logic       adc_sclk,
  output logic       adc_mosi,
  input  logic       adc_miso,
  // dac
  output logic       dac_cs,
  output logic       dac_sclk,
  output logic       dac_sdi,
  input  logic       dac_sdo,
  // flash
  output logic       flash_cs,
  output logic       flash_sclk,
  output logic       flash_mosi,
  input  logic       flash_miso,
  output logic [7:0] bad_frames
);

  logic [7:0]             reg_mux;
  logic [7:0]             reg_led;
  logic [3:0]             reg_dac;
  logic [`NUM_PERIPH-1:0] periph_cs;
  logic [`NUM_PERIPH-1:0] periph_sclk;
  logic [`NUM_PERIPH-1:0] periph_mosi;
  logic [`NUM_PERIPH-1:0] periph_miso;

  spi_sample_if smp_if ();
  spi_frame_if  frm_if ();

  ////////////////////////////////////////
  // register write pipeline

  spi_input_sync i_sync (
    .clk     (clk),
    .reset   (reset),
    .sclk    (spi_clk),
    .cs      (spi_cs),
    .mosi    (spi_mosi),
    .special (spi_special),
    .smp     (smp_if.src)
  );

  spi_frame_shifter i_shifter (
    .clk   (clk),
    .reset (reset),
    .smp   (smp_if.dst),
    .frm   (frm_if.src)
  );

  reg_bank_decode i_decode (
    .clk        (clk),
    .reset      (reset),
    .frm        (frm_if.dst),
    .reg_mux    (reg_mux),
    .reg_led    (reg_led),
    .reg_dac    (reg_dac),
    .bad_frames (bad_frames)
  );

  ////////////////////////////////////////
  // peripheral bus, straight from the pins

  periph_spi_router i_router (
    .cs          (spi_cs),
    .sclk        (spi_clk),
    .mosi        (spi_mosi),
    .special     (spi_special),
    .reg_mux     (reg_mux),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .miso        (spi_miso)
  );

  // bit 0 adc, bit 1 dac, bit 2 flash
  assign {flash_cs,   dac_cs,   adc_cs}   = periph_cs;
  assign {flash_sclk, dac_sclk, adc_sclk} = periph_sclk;
  assign {flash_mosi, dac_sdi,  adc_mosi} = periph_mosi;
  assign periph_miso = {flash_miso, dac_sdo, adc_miso};

  assign led = reg_led[1:0];
  assign {dac_uni_bip_b, dac_uni_bip_a, dac_rst, dac_ldac} = reg_dac;

endmodule

/* bench/spi_periph_hub_checker.sv */
module spi_periph_hub_checker (
  input  logic       clk,
  input  logic       check_regs,   // compare register outputs
  input  logic       check_bus,    // compare routed bus
  input  logic       test_done,
  input  logic [7:0] test_id,
  input  logic [1:0] exp_led,
  input  logic [3:0] exp_dac,
  input  logic [7:0] exp_bad,
  input  logic [2:0] exp_cs,
  input  logic       exp_miso,
  // dut ports, watched only
  input  logic       spi_clk,
  input  logic       spi_mosi,
  input  logic       spi_miso,
  input  logic [1:0] led,
  input  logic       dac_ldac,
  input  logic       dac_rst,
  input  logic       dac_uni_bip_a,
  input  logic       dac_uni_bip_b,
  input  logic       adc_cs,
  input  logic       adc_sclk,
  input  logic       adc_mosi,
  input  logic       dac_cs,
  input  logic       dac_sclk,
  input  logic       dac_sdi,
  input  logic       flash_cs,
  input  logic       flash_sclk,
  input  logic       flash_mosi,
  input  logic [7:0] bad_frames,
  output int         total_checks,
  output int         total_errors
);

  int test_checks;
  int test_errors;

  initial
  begin
    total_checks = 0;
    total_errors = 0;
    test_checks  = 0;
    test_errors  = 0;
  end

  task automatic compare_val(input string name, input logic [7:0] got, input logic [7:0] want);
    total_checks++;
    test_checks++;
    if (got !== want)
    begin
      total_errors++;
      test_errors++;
      $display("Error: %s is %h, expected %h", name, got, want);
    end
  endtask

  ////////////////////////////////////////
  // compare on the clock, inputs settled

  always @(posedge clk)
  begin
    if (check_regs)
    begin
      compare_val("led", 8'(led), 8'(exp_led));
      compare_val("{dac_uni_bip_b,dac_uni_bip_a,dac_rst,dac_ldac}",
                  8'({dac_uni_bip_b, dac_uni_bip_a, dac_rst, dac_ldac}), 8'(exp_dac));
      compare_val("bad_frames", bad_frames, exp_bad);
      compare_val("{flash_cs,dac_cs,adc_cs}", 8'({flash_cs, dac_cs, adc_cs}), 8'(exp_cs));
    end
    if (check_bus)
    begin
      compare_val("{flash_cs,dac_cs,adc_cs}", 8'({flash_cs, dac_cs, adc_cs}), 8'(exp_cs));
      // sclk and mosi fan out to all three
      compare_val("{flash_sclk,dac_sclk,adc_sclk}",
                  8'({flash_sclk, dac_sclk, adc_sclk}), 8'({3{spi_clk}}));
      compare_val("{flash_mosi,dac_sdi,adc_mosi}",
                  8'({flash_mosi, dac_sdi, adc_mosi}), 8'({3{spi_mosi}}));
      compare_val("spi_miso", 8'(spi_miso), 8'(exp_miso));
    end
    if (test_done)
    begin
      $display("test %0d finished: %0d checks, %0d errors", test_id, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

/* bench/spi_periph_hub_tb.sv */
`include "spi_hub_cfg.svh"

module spi_periph_hub_tb
  import spi_hub_pkg::*;
();

  logic       clk, reset;
  logic       spi_clk, spi_cs, spi_mosi, spi_special, spi_miso;
  logic [1:0] led;
  logic       dac_ldac, dac_rst, dac_uni_bip_a, dac_uni_bip_b;
  logic       adc_cs, adc_sclk, adc_mosi, adc_miso;
  logic       dac_cs, dac_sclk, dac_sdi, dac_sdo;
  logic       flash_cs, flash_sclk, flash_mosi, flash_miso;
  logic [7:0] bad_frames;

  // checker control and expectations
  logic       check_regs, check_bus, test_done;
  logic [7:0] test_id;
  logic [1:0] exp_led;
  logic [3:0] exp_dac;
  logic [7:0] exp_bad;
  logic [2:0] exp_cs;           // flash, dac, adc
  logic       exp_miso;
  int         total_checks, total_errors;

  // register model
  logic [7:0] m_mux, m_led, n_bad;
  logic [3:0] m_dac;
  int         timeouts;
  integer     seed = 32'h8e9a7179;

  spi_periph_hub i_dut (.*);
  spi_periph_hub_checker i_checker (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // reference model

  // next {mux, led, dac} after one accepted write frame
  function automatic logic [19:0] predict_regs(input logic [19:0] cur, input spi_frame_u f);
    logic [19:0] nxt;
    nxt = cur;
    case (f.wr.reg_addr)
      8'd8: nxt[19:12] = f.wr.reg_value;
      8'd7: nxt[11:4]  = f.wr.reg_value;
      8'd9: nxt[3:0]   = f.wr.reg_value[3:0];  // b, a, rst, ldac from msb
      default: ;
    endcase
    return nxt;
  endfunction

  ////////////////////////////////////////
  // spi master

  task automatic spi_xfer(input logic [31:0] data, input int nbits, input logic sp);
    logic [31:0] sh;
    logic [2:0]  pat;
    sh = data << (32 - nbits);              // msb of frame at [31]
    repeat (4) @(posedge clk);              // cs high gap
    spi_special <= sp;
    @(posedge clk);
    spi_cs <= 1'b0;
    for (int i = 0; i < nbits; i++)
    begin
      @(posedge clk);
      pat = 3'($random(seed));
      spi_mosi <= sh[31];
      {flash_miso, dac_sdo, adc_miso} <= pat;
      exp_cs   <= sp ? ~m_mux[2:0] : 3'b111;
      exp_miso <= |(pat & m_mux[2:0]);
      check_bus <= 1'b1;                    // mid bit, sclk low
      @(posedge clk);
      check_bus <= 1'b0;
      sh = sh << 1;
      repeat (2) @(posedge clk);
      spi_clk   <= 1'b1;
      check_bus <= 1'b1;                    // again with sclk high
      @(posedge clk);
      check_bus <= 1'b0;
      repeat (3) @(posedge clk);
      spi_clk <= 1'b0;
    end
    repeat (4) @(posedge clk);
    spi_cs <= 1'b1;
    exp_cs <= 3'b111;
  endtask

  task automatic check_registers();
    repeat (8) @(posedge clk);              // past the 5 clk pipeline
    exp_led    <= m_led[1:0];
    exp_dac    <= m_dac;
    exp_bad    <= n_bad;
    exp_cs     <= 3'b111;
    check_regs <= 1'b1;
    @(posedge clk);
    check_regs <= 1'b0;
  endtask

  task automatic write_frame(input logic [7:0] addr, input logic [7:0] value);
    spi_frame_u f;
    f.wr.reg_addr  = addr;
    f.wr.reg_value = value;
    spi_xfer({16'h0, f}, 16, 1'b0);
    {m_mux, m_led, m_dac} = predict_regs({m_mux, m_led, m_dac}, f);
    check_registers();
  endtask

  task automatic wait_bad_frames(input logic [7:0] want);
    int n;
    n = 0;
    while (bad_frames !== want && n < 40)
    begin
      @(posedge clk);
      n++;
    end
    if (bad_frames !== want)
    begin
      $display("timeout: bad frame counter never reached %0d", want);
      timeouts++;
    end
  endtask

  task automatic end_test(input logic [7:0] id);
    @(posedge clk);
    test_id   <= id;
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  function automatic logic [7:0] pick_addr(input logic [31:0] r);
    case (r[1:0])
      2'd0: return `ADDR_LED;
      2'd1: return `ADDR_MUX;
      2'd2: return `ADDR_DAC;
      default: return (r[15:8] inside {[8'd7:8'd9]}) ? 8'h5a : r[15:8];  // unmapped
    endcase
  endfunction

  ////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [31:0] r;
    reset       = 1'b1;
    spi_clk     = 1'b0;
    spi_cs      = 1'b1;
    spi_mosi    = 1'b0;
    spi_special = 1'b1;
    adc_miso    = 1'b0;
    dac_sdo     = 1'b0;
    flash_miso  = 1'b0;
    check_regs  = 1'b0;
    check_bus   = 1'b0;
    test_done   = 1'b0;
    test_id     = 8'd0;
    exp_led     = '0;
    exp_dac     = '0;
    exp_bad     = '0;
    exp_cs      = 3'b111;
    exp_miso    = 1'b0;
    m_mux       = '0;
    m_led       = '0;
    m_dac       = '0;
    n_bad       = '0;
    timeouts    = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    check_registers();                      // reset state
    end_test(8'd1);

    for (int k = 0; k < 12; k++)
    begin
      r = $random(seed);
      write_frame(pick_addr(r), r[23:16]);
    end
    end_test(8'd2);

    spi_xfer($random(seed), 15, 1'b0);      // short frame
    n_bad = n_bad + 1'b1;
    wait_bad_frames(n_bad);
    check_registers();
    spi_xfer($random(seed), 17, 1'b0);      // long frame
    n_bad = n_bad + 1'b1;
    wait_bad_frames(n_bad);
    check_registers();
    end_test(8'd3);

    for (int k = 0; k < 4; k++)
    begin
      r = $random(seed);
      write_frame(`ADDR_MUX, r[7:0]);
      spi_xfer($random(seed), 16, 1'b1);    // bus checks per bit
    end
    end_test(8'd4);

    // looks like a write, but special is high
    spi_xfer({16'h0, `ADDR_LED, ~m_led}, 16, 1'b1);
    check_registers();
    spi_xfer({16'h0, `ADDR_MUX, ~m_mux}, 16, 1'b1);
    check_registers();
    r = $random(seed);
    write_frame(`ADDR_DAC, r[7:0]);         // cs lines checked mid frame
    end_test(8'd5);

    repeat (2) @(posedge clk);
    $display("summary: %0d checks, %0d errors, %0d timeouts",
             total_checks, total_errors, timeouts);
    if (total_errors == 0 && timeouts == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* spi_periph_hub.f */
+incdir+include
verilog/spi_hub_pkg.sv
verilog/spi_hub_links.sv
verilog/spi_input_sync.sv
verilog/spi_frame_shifter.sv
verilog/reg_bank_decode.sv
verilog/periph_spi_router.sv
verilog/spi_periph_hub.sv
bench/spi_periph_hub_checker.sv
bench/spi_periph_hub_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module spi_periph_hub_tb \
  -f spi_periph_hub.f \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
